//--- Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tbQuplsCmpUnit
FILELIST = quplsCmpUnit.f
BUILDDIR = obj_dir
LOG      = sim.log

.PHONY: sim clean

sim:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILDDIR)
	./$(BUILDDIR)/V$(TOP) | tee $(LOG)
	grep -q "Simulation PASSED" $(LOG)

clean:
	rm -rf $(BUILDDIR) $(LOG)

//--- hw/branchEval.sv
`timescale 1ns/1ps

module branchEval
(
	input logic clk,
	input logic reset,
	input logic brValid,
	input logic [quplsCmpPkg::CondIdxWidth-1:0] brIdx,
	input logic [quplsCmpPkg::BitIdxWidth-1:0] brBit,
	input quplsCmpPkg::condVec_t rdVec,
	output logic [quplsCmpPkg::CondIdxWidth-1:0] rdIdx,
	output logic brDone,
	output logic brTaken
);

	// Selected condition bit, forced low for an out-of-range bit number
	logic condBit;

	// The condition file is read directly with the request's register index
	assign rdIdx = brIdx;

	assign condBit = (brBit < quplsCmpPkg::CondBits) &&
		rdVec[brBit[quplsCmpPkg::CondSelWidth-1:0]];

	// =========================================================================
	// Branch decision register
	// =========================================================================

	// brTaken is only meaningful while brDone is high
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			brDone <= 1'b0;
			brTaken <= 1'b0;
		end
		else
		begin
			brDone <= brValid;
			brTaken <= brValid && condBit;
		end
	end

	// Branch conditions only name bits that a condition vector holds
	assert property (@(posedge clk) disable iff (reset)
		brValid |-> brBit < quplsCmpPkg::CondBits)
	else
		$error("branchEval: branch bit out of range");

endmodule

//--- hw/cmpIssueReg.sv
`timescale 1ns/1ps

module cmpIssueReg
(
	input logic clk,
	input logic reset,
	input logic issueValid,
	input quplsCmpPkg::instruction_t issueIr,
	input quplsCmpPkg::data_t opA,
	input quplsCmpPkg::data_t opB,
	output quplsCmpPkg::cmpIssue_t issue,
	output logic issueOut
);

	// Immediate widened both ways, the opcode decides which one is used
	quplsCmpPkg::data_t immSext;
	quplsCmpPkg::data_t immZext;
	// Second operand as the compare will see it
	quplsCmpPkg::data_t bSel;

	// =========================================================================
	// Second operand selection
	// =========================================================================

	assign immSext =
	{
		{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){issueIr.imm[quplsCmpPkg::ImmWidth-1]}},
		issueIr.imm
	};
	assign immZext =
	{
		{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){1'b0}},
		issueIr.imm
	};

	// Register forms and unknown opcodes take the register operand;
	// the compare zeroes the vector for unknown opcodes anyway
	always_comb
	begin
		case (issueIr.opcode)
		quplsCmpPkg::OP_CMPI:
			bSel = immSext;
		quplsCmpPkg::OP_CMPUI:
			bSel = immZext;
		default:
			bSel = opB;
		endcase
	end

	// =========================================================================
	// Issue register
	// =========================================================================

	// Valid bit of the stage, one new compare may arrive every cycle
	always_ff @(posedge clk)
	begin
		if (reset)
			issueOut <= 1'b0;
		else
			issueOut <= issueValid;
	end

	// Payload is only loaded with a valid issue and is qualified by issueOut
	always_ff @(posedge clk)
	begin
		if (issueValid)
			issue <= '{ir: issueIr, a: opA, b: bSel};
	end

	// An issued instruction word must be fully driven by the scheduler
	assert property (@(posedge clk) disable iff (reset)
		issueValid |-> !$isunknown(issueIr))
	else
		$error("cmpIssueReg: unknown bits in issued instruction");

endmodule

//--- hw/condRegFile.sv
`timescale 1ns/1ps

module condRegFile
(
	input logic clk,
	input logic reset,
	input quplsCmpPkg::condWrite_t wr,
	input logic [quplsCmpPkg::CondIdxWidth-1:0] rdIdx,
	output quplsCmpPkg::condVec_t rdVec
);

	// Architectural condition registers
	quplsCmpPkg::condVec_t regs [quplsCmpPkg::CondRegs];

	// =========================================================================
	// Write port
	// =========================================================================

	// All registers come out of reset as zero, so an early branch is not taken
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			for (int i = 0; i < quplsCmpPkg::CondRegs; i++)
				regs[i] <= '0;
		end
		else if (wr.valid)
			regs[wr.idx] <= wr.vec;
	end

	// Asynchronous read, a same-edge write is seen only after that edge
	assign rdVec = regs[rdIdx];

	// =========================================================================
	// Checks
	// =========================================================================

	// The destination index comes from the issued instruction
	assert property (@(posedge clk) disable iff (reset)
		wr.valid |-> !$isunknown(wr.idx))
	else
		$error("condRegFile: unknown write index");

endmodule

//--- hw/quplsCmp.sv
`timescale 1ns/1ps

module quplsCmp
(
	input quplsCmpPkg::cmpIssue_t issue,
	output quplsCmpPkg::condVec_t cond
);

	// Result of a full signed compare with bit tests
	quplsCmpPkg::condVec_t signedVec;
	// Result of an unsigned compare, magnitude bits only
	quplsCmpPkg::condVec_t unsignedVec;
	// Operand bit picked by the low bits of the second operand
	logic selBit;

	// =========================================================================
	// Compare results
	// =========================================================================

	// The bit tests look at operand a, indexed by the low bits of b
	assign selBit = issue.a[issue.b[quplsCmpPkg::BitIdxWidth-1:0]];

	// Signed ordering plus equality and the bit tests
	always_comb
	begin
		signedVec = '0;
		signedVec[quplsCmpPkg::CondEq] = issue.a == issue.b;
		signedVec[quplsCmpPkg::CondNe] = issue.a != issue.b;
		signedVec[quplsCmpPkg::CondLt] = $signed(issue.a) < $signed(issue.b);
		signedVec[quplsCmpPkg::CondLe] = $signed(issue.a) <= $signed(issue.b);
		signedVec[quplsCmpPkg::CondGe] = $signed(issue.a) >= $signed(issue.b);
		signedVec[quplsCmpPkg::CondGt] = $signed(issue.a) > $signed(issue.b);
		// Bit clear and bit set are always complementary
		signedVec[quplsCmpPkg::CondBc] = ~selBit;
		signedVec[quplsCmpPkg::CondBs] = selBit;
	end

	// Unsigned forms only report ordering, eq, ne and the bit tests stay clear
	always_comb
	begin
		unsignedVec = '0;
		unsignedVec[quplsCmpPkg::CondLt] = issue.a < issue.b;
		unsignedVec[quplsCmpPkg::CondLe] = issue.a <= issue.b;
		unsignedVec[quplsCmpPkg::CondGe] = issue.a >= issue.b;
		unsignedVec[quplsCmpPkg::CondGt] = issue.a > issue.b;
	end

	// =========================================================================
	// Opcode and function decode
	// =========================================================================

	// Anything the slice does not recognise produces an all-zero vector,
	// which still gets written to the destination register
	always_comb
	begin
		cond = '0;
		case (issue.ir.opcode)
		quplsCmpPkg::OP_R2:
			case (issue.ir.func)
			quplsCmpPkg::FN_CMP:
				cond = signedVec;
			quplsCmpPkg::FN_CMPU:
				cond = unsignedVec;
			default:
				cond = '0;
			endcase
		// Immediate forms ignore func, the immediate is already in b
		quplsCmpPkg::OP_CMPI:
			cond = signedVec;
		quplsCmpPkg::OP_CMPUI:
			cond = unsignedVec;
		default:
			cond = '0;
		endcase
	end

endmodule

//--- hw/quplsCmpPkg.sv
package quplsCmpPkg;

	// =========================================================================
	// Widths
	// =========================================================================

	// Integer operand width of the execute stage
	localparam int DataWidth = 64;
	// Low operand bits that pick the bit for the bit-clear and bit-set tests
	localparam int BitIdxWidth = 6;
	// Width of one condition vector
	localparam int CondBits = 16;
	// Index width that selects one bit out of a condition vector
	localparam int CondSelWidth = 4;
	// Number of architectural condition registers
	localparam int CondRegs = 8;
	localparam int CondIdxWidth = 3;
	// Immediate field carried in the compare instruction word
	localparam int ImmWidth = 16;

	// =========================================================================
	// Condition vector layout
	// =========================================================================

	// Bit positions inside a condition vector, bits 8 to 15 stay zero
	localparam int CondEq = 0;
	localparam int CondNe = 1;
	localparam int CondLt = 2;
	localparam int CondLe = 3;
	localparam int CondGe = 4;
	localparam int CondGt = 5;
	localparam int CondBc = 6;
	localparam int CondBs = 7;

	typedef logic [CondBits-1:0] condVec_t;
	typedef logic [DataWidth-1:0] data_t;

	// =========================================================================
	// Instruction format
	// =========================================================================

	// Major opcodes handled by the compare slice
	typedef enum logic [6:0]
	{
		OP_R2 = 7'd2,
		OP_CMPI = 7'd11,
		OP_CMPUI = 7'd12
	} opcode_t;

	// Function codes of the register-register format
	typedef enum logic [5:0]
	{
		FN_CMP = 6'd13,
		FN_CMPU = 6'd14
	} func_t;

	// The func field is only meaningful for OP_R2
	typedef struct packed
	{
		opcode_t opcode;
		logic [CondIdxWidth-1:0] crd;
		func_t func;
		logic [ImmWidth-1:0] imm;
	} instruction_t;

	// Issued compare with the second operand already resolved
	typedef struct packed
	{
		instruction_t ir;
		data_t a;
		data_t b;
	} cmpIssue_t;

	// One write into the condition register file
	typedef struct packed
	{
		logic valid;
		logic [CondIdxWidth-1:0] idx;
		condVec_t vec;
	} condWrite_t;

endpackage

//--- hw/quplsCmpUnit.sv
`timescale 1ns/1ps

module quplsCmpUnit
(
	input logic clk,
	input logic reset,
	// Compare issue
	input logic issueValid,
	input quplsCmpPkg::instruction_t issueIr,
	input quplsCmpPkg::data_t opA,
	input quplsCmpPkg::data_t opB,
	// Compare result
	output logic cmpResultValid,
	output quplsCmpPkg::condVec_t cmpResult,
	output logic [quplsCmpPkg::CondIdxWidth-1:0] cmpResultIdx,
	// Branch request and outcome
	input logic brValid,
	input logic [quplsCmpPkg::CondIdxWidth-1:0] brIdx,
	input logic [quplsCmpPkg::BitIdxWidth-1:0] brBit,
	output logic brDone,
	output logic brTaken
);

	quplsCmpPkg::cmpIssue_t issue;
	logic issueOut;
	quplsCmpPkg::condVec_t cond;
	quplsCmpPkg::condWrite_t condWr;
	logic [quplsCmpPkg::CondIdxWidth-1:0] rdIdx;
	quplsCmpPkg::condVec_t rdVec;

	// =========================================================================
	// Compare path
	// =========================================================================

	cmpIssueReg u_cmpIssueReg
	(
		.clk(clk),
		.reset(reset),
		.issueValid(issueValid),
		.issueIr(issueIr),
		.opA(opA),
		.opB(opB),
		.issue(issue),
		.issueOut(issueOut)
	);

	// Vector is ready in the cycle after issue
	quplsCmp u_quplsCmp
	(
		.issue(issue),
		.cond(cond)
	);

	assign cmpResultValid = issueOut;
	assign cmpResult = cond;
	assign cmpResultIdx = issue.ir.crd;

	// the result is written back on the next edge
	assign condWr = '{valid: issueOut, idx: issue.ir.crd, vec: cond};

	// =========================================================================
	// Condition registers and branch evaluation
	// =========================================================================

	condRegFile u_condRegFile
	(
		.clk(clk),
		.reset(reset),
		.wr(condWr),
		.rdIdx(rdIdx),
		.rdVec(rdVec)
	);

	branchEval u_branchEval
	(
		.clk(clk),
		.reset(reset),
		.brValid(brValid),
		.brIdx(brIdx),
		.brBit(brBit),
		.rdVec(rdVec),
		.rdIdx(rdIdx),
		.brDone(brDone),
		.brTaken(brTaken)
	);

endmodule

//--- quplsCmpUnit.f
hw/quplsCmpPkg.sv
hw/cmpIssueReg.sv
hw/quplsCmp.sv
hw/condRegFile.sv
hw/branchEval.sv
hw/quplsCmpUnit.sv
tb/tbQuplsCmpUnit.sv

//--- tb/tbQuplsCmpUnit.sv
`timescale 1ns/1ps

module tbQuplsCmpUnit;

	// Operation counts per test, the watchdog budget is derived from their sum
	localparam int NumReset = 16;
	localparam int NumCompare = 60;
	localparam int NumUnknown = 40;
	localparam int NumBranch = 40;
	localparam int NumMixed = 200;
	localparam int TotalOps = NumReset + 4 * NumCompare + NumUnknown + NumBranch + NumMixed + 40;

	logic clk;
	logic reset;
	logic issueValid;
	quplsCmpPkg::instruction_t issueIr;
	quplsCmpPkg::data_t opA;
	quplsCmpPkg::data_t opB;
	logic cmpResultValid;
	quplsCmpPkg::condVec_t cmpResult;
	logic [quplsCmpPkg::CondIdxWidth-1:0] cmpResultIdx;
	logic brValid;
	logic [quplsCmpPkg::CondIdxWidth-1:0] brIdx;
	logic [quplsCmpPkg::BitIdxWidth-1:0] brBit;
	logic brDone;
	logic brTaken;

	integer seed;
	int errors;
	int checks;
	string testName;

	// Shadow of the condition registers and the expectations due at the next falling edge
	quplsCmpPkg::condVec_t shadow [quplsCmpPkg::CondRegs];
	logic pendCmp;
	quplsCmpPkg::condVec_t pendVec;
	logic [quplsCmpPkg::CondIdxWidth-1:0] pendIdx;
	logic pendBr;
	logic pendTaken;

	quplsCmpUnit u_quplsCmpUnit
	(
		.clk(clk),
		.reset(reset),
		.issueValid(issueValid),
		.issueIr(issueIr),
		.opA(opA),
		.opB(opB),
		.cmpResultValid(cmpResultValid),
		.cmpResult(cmpResult),
		.cmpResultIdx(cmpResultIdx),
		.brValid(brValid),
		.brIdx(brIdx),
		.brBit(brBit),
		.brDone(brDone),
		.brTaken(brTaken)
	);

	initial
	begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	// ========================================================================
	// Reference model and random sources
	// ========================================================================

	// Condition vector rebuilt from the layout rules of the compare slice
	function automatic quplsCmpPkg::condVec_t expectedCond(input quplsCmpPkg::instruction_t ir,
		input quplsCmpPkg::data_t a, input quplsCmpPkg::data_t opBIn);
		quplsCmpPkg::data_t b;
		longint sa;
		longint sb;
		logic isSigned;
		logic isUnsigned;
		quplsCmpPkg::condVec_t v;
		b = opBIn;
		isSigned = 1'b0;
		isUnsigned = 1'b0;
		v = '0;
		if (ir.opcode == quplsCmpPkg::OP_CMPI)
		begin
			b = {{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){ir.imm[15]}}, ir.imm};
			isSigned = 1'b1;
		end
		else if (ir.opcode == quplsCmpPkg::OP_CMPUI)
		begin
			b = {{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){1'b0}}, ir.imm};
			isUnsigned = 1'b1;
		end
		else if (ir.opcode == quplsCmpPkg::OP_R2)
		begin
			isSigned = (ir.func == quplsCmpPkg::FN_CMP);
			isUnsigned = (ir.func == quplsCmpPkg::FN_CMPU);
		end
		sa = a;
		sb = b;
		if (isSigned)
		begin
			v[0] = (a == b);
			v[1] = (a != b);
			v[2] = (sa < sb);
			v[3] = (sa <= sb);
			v[4] = (sa >= sb);
			v[5] = (sa > sb);
			// Bit tests look at a, numbered by the low six bits of b
			v[7] = a[b[5:0]];
			v[6] = ~a[b[5:0]];
		end
		else if (isUnsigned)
		begin
			v[2] = (a < b);
			v[3] = (a <= b);
			v[4] = (a >= b);
			v[5] = (a > b);
		end
		return v;
	endfunction

	function automatic int randRange(input int n);
		return int'($unsigned($random(seed)) % n);
	endfunction

	// Mix of wide random, small signed and sign-boundary values
	function automatic quplsCmpPkg::data_t randOperand();
		quplsCmpPkg::data_t v;
		int mode;
		mode = randRange(4);
		v = {$random(seed), $random(seed)};
		if (mode == 1)
		begin
			v = 64'(randRange(16));
			if (randRange(2) == 1)
				v = -v;
		end
		else if (mode == 2)
		begin
			case (randRange(5))
			0: v = 64'h8000_0000_0000_0000;
			1: v = 64'h7fff_ffff_ffff_ffff;
			2: v = '1;
			3: v = '0;
			default: v = 64'd1;
			endcase
		end
		else if (mode == 3)
			v[63] = 1'b1;
		return v;
	endfunction

	// Kinds 0 to 3 are CMP, CMPU, CMPI and CMPUI, kind 4 is an unknown operation
	task automatic genIssue(input int kind, output quplsCmpPkg::instruction_t ir,
		output quplsCmpPkg::data_t a, output quplsCmpPkg::data_t b);
		logic [6:0] op;
		logic [5:0] fn;
		logic [15:0] imm;
		logic [2:0] crd;
		crd = 3'(randRange(8));
		fn = 6'(randRange(64));
		imm = (randRange(3) == 0) ? 16'h8000 - 16'(randRange(3)) : 16'($random(seed));
		a = randOperand();
		b = randOperand();
		op = quplsCmpPkg::OP_R2;
		case (kind)
		0: fn = quplsCmpPkg::FN_CMP;
		1: fn = quplsCmpPkg::FN_CMPU;
		2: op = quplsCmpPkg::OP_CMPI;
		3: op = quplsCmpPkg::OP_CMPUI;
		default:
		begin
			if (randRange(2) == 1)
			begin
				while (fn == quplsCmpPkg::FN_CMP || fn == quplsCmpPkg::FN_CMPU)
					fn = 6'(randRange(64));
			end
			else
			begin
				op = 7'(randRange(128));
				while (op == quplsCmpPkg::OP_R2 || op == quplsCmpPkg::OP_CMPI ||
					op == quplsCmpPkg::OP_CMPUI)
					op = 7'(randRange(128));
			end
		end
		endcase
		// Equal operands hit the eq, le and ge bits together
		if (randRange(4) == 0)
		begin
			if (kind == 2)
				a = {{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){imm[15]}}, imm};
			else if (kind == 3)
				a = {{(quplsCmpPkg::DataWidth - quplsCmpPkg::ImmWidth){1'b0}}, imm};
			else
				b = a;
		end
		ir = quplsCmpPkg::instruction_t'({op, crd, fn, imm});
	endtask

	// ========================================================================
	// Cycle driver and checks
	// ========================================================================

	task automatic checkValue(input string what, input logic [63:0] expV, input logic [63:0] actV);
		checks++;
		if (actV !== expV)
		begin
			errors++;
			$display("Fail %s: %s expected %0h actual %0h", testName, what, expV, actV);
		end
	endtask

	// Checks what the last rising edge produced, then drives the next inputs
	task automatic stepCycle(input logic doIssue, input quplsCmpPkg::instruction_t ir,
		input quplsCmpPkg::data_t a, input quplsCmpPkg::data_t b, input logic doBr,
		input logic [2:0] bIdx, input logic [5:0] bBit);
		logic newTaken;
		@(negedge clk);
		checkValue("cmpResultValid", 64'(pendCmp), 64'(cmpResultValid));
		if (pendCmp)
		begin
			checkValue("cmpResult", 64'(pendVec), 64'(cmpResult));
			checkValue("cmpResultIdx", 64'(pendIdx), 64'(cmpResultIdx));
		end
		checkValue("brDone", 64'(pendBr), 64'(brDone));
		if (pendBr)
			checkValue("brTaken", 64'(pendTaken), 64'(brTaken));
		// A branch sampled at the coming edge sees the register before this write
		newTaken = doBr && shadow[bIdx][bBit[3:0]];
		if (pendCmp)
			shadow[pendIdx] = pendVec;
		issueValid = doIssue;
		if (doIssue)
		begin
			issueIr = ir;
			opA = a;
			opB = b;
		end
		brValid = doBr;
		brIdx = bIdx;
		brBit = bBit;
		pendCmp = doIssue;
		pendVec = expectedCond(ir, a, b);
		pendIdx = ir.crd;
		pendBr = doBr;
		pendTaken = newTaken;
	endtask

	task automatic runCompares(input string name, input int kind, input int count);
		quplsCmpPkg::instruction_t ir;
		quplsCmpPkg::data_t a;
		quplsCmpPkg::data_t b;
		testName = name;
		repeat (count)
		begin
			genIssue(kind, ir, a, b);
			stepCycle(randRange(4) != 0, ir, a, b, 1'b0, 3'd0, 6'd0);
		end
		repeat (2)
			stepCycle(1'b0, ir, a, b, 1'b0, 3'd0, 6'd0);
	endtask

	// Issues every cycle when withIssue is set, branches at random otherwise always
	task automatic runBranches(input string name, input int count, input logic withIssue);
		quplsCmpPkg::instruction_t ir;
		quplsCmpPkg::data_t a;
		quplsCmpPkg::data_t b;
		testName = name;
		ir = '0;
		a = '0;
		b = '0;
		repeat (count)
		begin
			if (withIssue)
				genIssue(randRange(5), ir, a, b);
			stepCycle(withIssue, ir, a, b, !withIssue || randRange(2) == 1,
				3'(randRange(8)), 6'(randRange(16)));
		end
		repeat (2)
			stepCycle(1'b0, ir, a, b, 1'b0, 3'd0, 6'd0);
	endtask

	// ========================================================================
	// Test sequence
	// ========================================================================

	initial
	begin
		seed = 28;
		errors = 0;
		checks = 0;
		reset = 1'b1;
		issueValid = 1'b0;
		issueIr = '0;
		opA = '0;
		opB = '0;
		brValid = 1'b0;
		brIdx = '0;
		brBit = '0;
		pendCmp = 1'b0;
		pendVec = '0;
		pendIdx = '0;
		pendBr = 1'b0;
		pendTaken = 1'b0;
		for (int i = 0; i < quplsCmpPkg::CondRegs; i++)
			shadow[i] = '0;
		repeat (8) @(negedge clk);
		reset = 1'b0;
		// Registers are all zero here, so every branch must fall through
		runBranches("afterReset", NumReset, 1'b0);
		runCompares("cmpSigned", 0, NumCompare);
		runCompares("cmpUnsigned", 1, NumCompare);
		runCompares("cmpImmSigned", 2, NumCompare);
		runCompares("cmpImmUnsigned", 3, NumCompare);
		runCompares("unknownOp", 4, NumUnknown);
		runBranches("branches", NumBranch, 1'b0);
		runBranches("backToBack", NumMixed, 1'b1);
		$display("Checks: %0d, errors: %0d", checks, errors);
		if (errors == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

	// Two cycles of 100 ns per operation at most, plus reset and flush time
	initial
	begin
		#(TotalOps * 200 + 5000);
		$display("Watchdog timeout: the test sequence did not finish in time");
		$display("Simulation FAILED");
		$finish;
	end

endmodule
